//--- rv_core_pkg.sv
package rv_core_pkg;

   localparam int XLEN   = 64;
   localparam int ADDR_W = 39;   // sv39 physical bus

   typedef logic [XLEN-1:0]   word_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [31:0]       instr_t;
   typedef logic [4:0]        reg_idx_t;
   typedef logic [2:0]        ls_type_t;   // funct3 of load or store

   localparam addr_t RAM_BASE = 39'h00_8000_0000;   // reset fetch address

   // major opcodes
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_IMM_W  = 7'b0011011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_REG_W  = 7'b0111011;

   localparam instr_t NOP_INSTR = 32'h0000_0013;   // addi x0,x0,0

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
   } alu_op_t;

   typedef enum logic [2:0] {
      CLS_ALU, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_LOAD, CLS_STORE, CLS_NOP
   } op_class_t;

   typedef enum logic {LSU_IDLE, LSU_WAIT} lsu_state_t;

   typedef struct packed {
      instr_t instr;
      addr_t  addr;   // address this instruction came from
   } fetch_t;

   typedef struct packed {
      op_class_t cls;
      alu_op_t   alu_op;
      logic      is_word;   // 32-bit op, result sign extended
      logic      use_imm;   // operand b from immediate
      logic      use_pc;    // operand a from pc
      reg_idx_t  rd;
      reg_idx_t  rs1;
      reg_idx_t  rs2;
      ls_type_t  funct3;
      word_t     imm;
   } dec_t;

   typedef struct packed {
      logic  valid;
      addr_t target;
   } redirect_t;

   typedef struct packed {
      logic     valid;
      logic     write;
      addr_t    addr;
      word_t    data;
      ls_type_t ls_type;
      reg_idx_t rd;
   } mem_req_t;

   typedef struct packed {
      addr_t    address;
      word_t    write_data;
      logic     read_enable;
      logic     write_enable;
      ls_type_t ls_type;
   } bus_req_t;

   typedef struct packed {
      logic     we;
      reg_idx_t rd;
      word_t    data;
   } wb_t;

endpackage

//--- rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
   input  logic                   clk,
   input  logic                   reset,
   input  rv_core_pkg::instr_t    instruction_i,   // word at pc_o
   input  rv_core_pkg::redirect_t redirect_i,
   input  logic                   stall_i,         // lsu waiting on bus
   output rv_core_pkg::addr_t     pc_o,
   output rv_core_pkg::fetch_t    cur_o            // executing instruction
);
   import rv_core_pkg::*;

   addr_t  pc_q;
   fetch_t cur_q;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc_q        <= RAM_BASE;
         cur_q.instr <= NOP_INSTR;
         cur_q.addr  <= RAM_BASE;
      end else if (!stall_i) begin
         if (redirect_i.valid) begin
            pc_q        <= redirect_i.target;
            cur_q.instr <= NOP_INSTR;   // wrong-path word dropped, one bubble
            cur_q.addr  <= pc_q;
         end else begin
            pc_q        <= pc_q + addr_t'(4);
            cur_q.instr <= instruction_i;
            cur_q.addr  <= pc_q;        // keep own address, no pc-4 math later
         end
      end
      // stalled: hold pc and ir
   end

   assign pc_o  = pc_q;
   assign cur_o = cur_q;

endmodule

//--- rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
   input  rv_core_pkg::instr_t instr_i,
   output rv_core_pkg::dec_t   dec_o
);
   import rv_core_pkg::*;

   logic [6:0] opcode;
   logic [6:0] funct7;
   logic [2:0] funct3;
   word_t      imm_u, imm_i, imm_s, imm_j, imm_b;
   word_t      shamt6, shamt5;
   logic       sh_ok;    // legal shift-imm encoding, rv64
   logic       sh_w_ok;  // legal w-form shift or add encoding
   logic       alt_ok;   // funct7 0 or 0100000 where allowed

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   assign imm_u  = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
   assign imm_i  = {{52{instr_i[31]}}, instr_i[31:20]};
   assign imm_s  = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_j  = {{44{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
   assign imm_b  = {{52{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
   assign shamt6 = {58'b0, instr_i[25:20]};
   assign shamt5 = {59'b0, instr_i[24:20]};

   assign sh_ok   = (funct3 == 3'b001) ? (funct7[6:1] == 6'b0) :
                    (funct3 == 3'b101) ? (funct7[6:1] == 6'b0 || funct7[6:1] == 6'b010000) :
                    1'b1;
   assign alt_ok  = (funct7 == 7'b0) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
   assign sh_w_ok = (funct3 == 3'b000) ||
                    ((funct3 == 3'b001 || funct3 == 3'b101) && alt_ok);

   // funct3 to alu op, alt picks sub / sra
   function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b011:  return ALU_SLTU;
         3'b100:  return ALU_XOR;
         3'b101:  return alt ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   always_comb begin
      dec_o         = '0;
      dec_o.cls     = CLS_NOP;
      dec_o.alu_op  = ALU_ADD;
      dec_o.rs1     = instr_i[19:15];
      dec_o.rs2     = instr_i[24:20];
      dec_o.funct3  = funct3;
      case (opcode)
         OP_LUI: begin
            dec_o.cls = CLS_ALU;  dec_o.alu_op = ALU_PASS_B;
         end
         OP_AUIPC: begin
            dec_o.cls = CLS_ALU;  dec_o.use_pc = 1'b1;
         end
         OP_JAL:    dec_o.cls = CLS_JAL;
         OP_JALR:   if (funct3 == 3'b000) dec_o.cls = CLS_JALR;
         OP_BRANCH: if (funct3[2:1] != 2'b01) dec_o.cls = CLS_BRANCH;
         OP_LOAD:   if (funct3 != 3'b111) dec_o.cls = CLS_LOAD;
         OP_STORE:  if (!funct3[2]) dec_o.cls = CLS_STORE;
         OP_IMM: if (sh_ok) begin
            dec_o.cls    = CLS_ALU;
            dec_o.alu_op = alu_sel(funct3, funct3 == 3'b101 && instr_i[30]);   // addi never sub
         end
         OP_IMM_W: if (sh_w_ok) begin
            dec_o.cls     = CLS_ALU;
            dec_o.is_word = 1'b1;
            dec_o.alu_op  = alu_sel(funct3, funct3 == 3'b101 && instr_i[30]);
         end
         OP_REG: if (alt_ok) begin
            dec_o.cls    = CLS_ALU;
            dec_o.alu_op = alu_sel(funct3, instr_i[30]);
         end
         OP_REG_W: if (alt_ok && sh_w_ok) begin
            dec_o.cls     = CLS_ALU;
            dec_o.is_word = 1'b1;
            dec_o.alu_op  = alu_sel(funct3, instr_i[30]);
         end
         default: dec_o.cls = CLS_NOP;   // unknown executes as nop
      endcase

      // operand b source
      dec_o.use_imm = (opcode != OP_REG) && (opcode != OP_REG_W);
      case (opcode)
         OP_LUI, OP_AUIPC: dec_o.imm = imm_u;
         OP_JAL:           dec_o.imm = imm_j;
         OP_BRANCH:        dec_o.imm = imm_b;
         OP_STORE:         dec_o.imm = imm_s;
         OP_IMM:           dec_o.imm = (funct3[1:0] == 2'b01) ? shamt6 : imm_i;
         OP_IMM_W:         dec_o.imm = (funct3[1:0] == 2'b01) ? shamt5 : imm_i;
         default:          dec_o.imm = imm_i;
      endcase

      // rd only where a register is written
      if (dec_o.cls == CLS_ALU || dec_o.cls == CLS_JAL || dec_o.cls == CLS_JALR ||
          dec_o.cls == CLS_LOAD)
         dec_o.rd = instr_i[11:7];
   end

endmodule

//--- rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_core_pkg::reg_idx_t rs1_i,
   input  rv_core_pkg::reg_idx_t rs2_i,
   output rv_core_pkg::word_t    rs1_data_o,
   output rv_core_pkg::word_t    rs2_data_o,
   input  rv_core_pkg::wb_t      alu_wb_i,    // from execute
   input  rv_core_pkg::wb_t      load_wb_i    // from lsu, never same cycle
);
   import rv_core_pkg::*;

   word_t regs_q [32];   // x0..x31

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) regs_q[i] <= '0;
      end else begin
         if (alu_wb_i.we && alu_wb_i.rd != 5'd0) regs_q[alu_wb_i.rd] <= alu_wb_i.data;
         if (load_wb_i.we && load_wb_i.rd != 5'd0) regs_q[load_wb_i.rd] <= load_wb_i.data;
      end
   end

   // async read, x0 stays zero since never written
   assign rs1_data_o = regs_q[rs1_i];
   assign rs2_data_o = regs_q[rs2_i];

endmodule

//--- rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
   input  rv_core_pkg::fetch_t    cur_i,
   input  rv_core_pkg::dec_t      dec_i,
   input  rv_core_pkg::word_t     rs1_data_i,
   input  rv_core_pkg::word_t     rs2_data_i,
   input  logic                   lsu_busy_i,   // instr after a load/store waits
   output rv_core_pkg::redirect_t redirect_o,
   output rv_core_pkg::mem_req_t  mem_req_o,
   output rv_core_pkg::wb_t       wb_o
);
   import rv_core_pkg::*;

   word_t      op_a, op_b;
   word_t      sh_src;     // shift source, low word extended for w forms
   logic [5:0] shamt;
   word_t      alu_raw, alu_res;
   word_t      rs1_sum;    // rs1 + imm, jalr and load/store address
   word_t      link;
   addr_t      br_target;
   logic       taken;
   logic       go;         // instruction really executes this cycle

   assign go   = !lsu_busy_i;
   assign op_a = dec_i.use_pc ? {{(XLEN-ADDR_W){1'b0}}, cur_i.addr} : rs1_data_i;
   assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

   assign shamt  = dec_i.is_word ? {1'b0, op_b[4:0]} : op_b[5:0];
   assign sh_src = !dec_i.is_word ? op_a :
                   (dec_i.alu_op == ALU_SRA) ? {{32{op_a[31]}}, op_a[31:0]} :
                   {32'b0, op_a[31:0]};

   always_comb begin
      case (dec_i.alu_op)
         ALU_ADD:  alu_raw = op_a + op_b;
         ALU_SUB:  alu_raw = op_a - op_b;
         ALU_SLL:  alu_raw = op_a << shamt;
         ALU_SLT:  alu_raw = word_t'($signed(op_a) < $signed(op_b));
         ALU_SLTU: alu_raw = word_t'(op_a < op_b);
         ALU_XOR:  alu_raw = op_a ^ op_b;
         ALU_SRL:  alu_raw = sh_src >> shamt;
         ALU_SRA:  alu_raw = word_t'($signed(sh_src) >>> shamt);
         ALU_OR:   alu_raw = op_a | op_b;
         ALU_AND:  alu_raw = op_a & op_b;
         default:  alu_raw = op_b;          // lui
      endcase
   end

   // w forms keep 32 bits and sign extend
   assign alu_res = dec_i.is_word ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

   // branch decision on raw register values
   always_comb begin
      case (dec_i.funct3)
         3'b000:  taken = (rs1_data_i == rs2_data_i);                    // beq
         3'b001:  taken = (rs1_data_i != rs2_data_i);                    // bne
         3'b100:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));   // blt
         3'b101:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));  // bge
         3'b110:  taken = (rs1_data_i < rs2_data_i);                     // bltu
         default: taken = (rs1_data_i >= rs2_data_i);                    // bgeu
      endcase
   end

   assign rs1_sum   = rs1_data_i + dec_i.imm;
   assign br_target = cur_i.addr + dec_i.imm[ADDR_W-1:0];   // jal and branch
   assign link      = {{(XLEN-ADDR_W){1'b0}}, cur_i.addr + addr_t'(4)};

   always_comb begin
      redirect_o.valid  = go && (dec_i.cls == CLS_JAL || dec_i.cls == CLS_JALR ||
                                 (dec_i.cls == CLS_BRANCH && taken));
      redirect_o.target = (dec_i.cls == CLS_JALR) ? {rs1_sum[ADDR_W-1:1], 1'b0} : br_target;
   end

   always_comb begin
      mem_req_o.valid   = go && (dec_i.cls == CLS_LOAD || dec_i.cls == CLS_STORE);
      mem_req_o.write   = (dec_i.cls == CLS_STORE);
      mem_req_o.addr    = rs1_sum[ADDR_W-1:0];
      mem_req_o.data    = rs2_data_i;   // lsu trims to width
      mem_req_o.ls_type = dec_i.funct3;
      mem_req_o.rd      = dec_i.rd;
   end

   always_comb begin
      wb_o.we   = go && (dec_i.cls == CLS_ALU || dec_i.cls == CLS_JAL ||
                         dec_i.cls == CLS_JALR);
      wb_o.rd   = dec_i.rd;
      wb_o.data = (dec_i.cls == CLS_ALU) ? alu_res : link;   // jumps write pc+4
   end

endmodule

//--- rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_core_pkg::mem_req_t mem_req_i,
   input  logic                  bus_read_done_i,
   input  logic                  bus_write_done_i,
   input  rv_core_pkg::word_t    bus_read_data_i,
   output rv_core_pkg::bus_req_t bus_o,
   output logic                  busy_o,   // core stall
   output rv_core_pkg::wb_t      wb_o      // load result
);
   import rv_core_pkg::*;

   lsu_state_t state_q;
   logic       write_q;            // pending op is a store
   logic       rd_en_q, wr_en_q;   // one-cycle strobes
   addr_t      addr_q;
   word_t      wdata_q;
   ls_type_t   ls_type_q;
   reg_idx_t   rd_q;
   word_t      store_mask;
   word_t      load_ext;
   logic       done;
   logic       accept;

   assign accept = (state_q == LSU_IDLE) && mem_req_i.valid;
   assign done   = write_q ? bus_write_done_i : bus_read_done_i;

   always_comb begin
      case (mem_req_i.ls_type[1:0])
         2'b00:   store_mask = 64'h0000_0000_0000_00ff;   // sb
         2'b01:   store_mask = 64'h0000_0000_0000_ffff;   // sh
         2'b10:   store_mask = 64'h0000_0000_ffff_ffff;   // sw
         default: store_mask = '1;                        // sd
      endcase
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state_q <= LSU_IDLE;
         write_q <= 1'b0;
         rd_en_q <= 1'b0;
         wr_en_q <= 1'b0;
      end else begin
         rd_en_q <= 1'b0;
         wr_en_q <= 1'b0;
         case (state_q)
            LSU_IDLE: if (accept) begin
               state_q <= LSU_WAIT;
               write_q <= mem_req_i.write;
               rd_en_q <= !mem_req_i.write;
               wr_en_q <= mem_req_i.write;
            end
            default: if (done) state_q <= LSU_IDLE;   // done may come with the strobe
         endcase
      end
   end

   // request payload, held stable until done
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q    <= mem_req_i.addr;
         wdata_q   <= mem_req_i.data & store_mask;
         ls_type_q <= mem_req_i.ls_type;
         rd_q      <= mem_req_i.rd;
      end
   end

   always_comb begin
      case (ls_type_q)
         3'b000:  load_ext = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};     // lb
         3'b001:  load_ext = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]};   // lh
         3'b010:  load_ext = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};   // lw
         3'b100:  load_ext = {56'b0, bus_read_data_i[7:0]};                       // lbu
         3'b101:  load_ext = {48'b0, bus_read_data_i[15:0]};                      // lhu
         3'b110:  load_ext = {32'b0, bus_read_data_i[31:0]};                      // lwu
         default: load_ext = bus_read_data_i;                                     // ld
      endcase
   end

   assign wb_o.we   = (state_q == LSU_WAIT) && !write_q && bus_read_done_i;
   assign wb_o.rd   = rd_q;
   assign wb_o.data = load_ext;

   assign busy_o = (state_q == LSU_WAIT);

   assign bus_o = '{address: addr_q, write_data: wdata_q, read_enable: rd_en_q,
                    write_enable: wr_en_q, ls_type: ls_type_q};

endmodule

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_core_pkg::instr_t   instruction_i,   // combinational reply to pc_o
   output rv_core_pkg::addr_t    pc_o,
   output rv_core_pkg::bus_req_t bus_o,
   input  logic                  bus_read_done_i,
   input  logic                  bus_write_done_i,
   input  rv_core_pkg::word_t    bus_read_data_i
);
   import rv_core_pkg::*;

   fetch_t    cur;
   dec_t      dec;
   word_t     rs1_data, rs2_data;
   redirect_t redirect;
   mem_req_t  mem_req;
   wb_t       alu_wb, load_wb;
   logic      lsu_busy;   // also the fetch stall

   rv_fetch u_fetch (
      .clk(clk), .reset(reset), .instruction_i(instruction_i),
      .redirect_i(redirect), .stall_i(lsu_busy), .pc_o(pc_o), .cur_o(cur)
   );

   rv_decode u_decode (.instr_i(cur.instr), .dec_o(dec));

   rv_regfile u_regfile (
      .clk(clk), .reset(reset), .rs1_i(dec.rs1), .rs2_i(dec.rs2),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
      .alu_wb_i(alu_wb), .load_wb_i(load_wb)
   );

   rv_execute u_execute (
      .cur_i(cur), .dec_i(dec), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
      .lsu_busy_i(lsu_busy), .redirect_o(redirect), .mem_req_o(mem_req), .wb_o(alu_wb)
   );

   rv_lsu u_lsu (
      .clk(clk), .reset(reset), .mem_req_i(mem_req),
      .bus_read_done_i(bus_read_done_i), .bus_write_done_i(bus_write_done_i),
      .bus_read_data_i(bus_read_data_i), .bus_o(bus_o), .busy_o(lsu_busy), .wb_o(load_wb)
   );

endmodule

//--- rv_core_assert.sv
`timescale 1ns/10ps

module rv_core_assert (
   input logic                  clk,
   input logic                  reset,
   input rv_core_pkg::bus_req_t bus_o,
   input rv_core_pkg::addr_t    pc_o,
   input logic                  bus_read_done_i,
   input logic                  bus_write_done_i
);
   import rv_core_pkg::*;

   logic en, done;
   logic open_q;   // request out, done not yet seen

   assign en   = bus_o.read_enable || bus_o.write_enable;
   assign done = bus_read_done_i || bus_write_done_i;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) open_q <= 1'b0;
      else if (en) open_q <= !done;   // done may come with the strobe
      else if (done) open_q <= 1'b0;
   end

   a_one_enable: assert property (@(posedge clk) disable iff (!reset)
      !(bus_o.read_enable && bus_o.write_enable)) else $error("read and write enable together");
   a_pulse: assert property (@(posedge clk) disable iff (!reset)
      en |=> !en) else $error("bus enable longer than one cycle");
   a_no_overlap: assert property (@(posedge clk) disable iff (!reset)
      en |-> !open_q) else $error("new bus request before done");
   a_pc_align: assert property (@(posedge clk) disable iff (!reset)
      pc_o[1:0] == 2'b00) else $error("fetch address not word aligned");

endmodule

bind rv_core rv_core_assert u_assert (
   .clk(clk), .reset(reset), .bus_o(bus_o), .pc_o(pc_o),
   .bus_read_done_i(bus_read_done_i), .bus_write_done_i(bus_write_done_i)
);

//--- rv_core_tb_clk.sv
`timescale 1ns/10ps

module rv_core_tb_clk (
   output logic clk_o,
   output logic reset_o   // active low
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;   // 100 ns period
   end

   initial begin
      reset_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b1;   // release away from the active edge
   end

endmodule

//--- rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;
   import rv_core_pkg::*;

   logic     clk, reset;
   instr_t   instruction_i;
   addr_t    pc_o;
   bus_req_t bus_o;
   logic     bus_read_done_i, bus_write_done_i;
   word_t    bus_read_data_i;

   instr_t      imem [$];          // program, word per slot from RAM_BASE
   logic [7:0]  dmem [addr_t];     // data bytes written so far
   addr_t       exp_addr [$];      // expected stores in order
   word_t       exp_data [$];
   ls_type_t    exp_type [$];      // store width per expected store
   logic [31:0] lfsr = 32'd67;
   int          data_ptr = 'h100;  // operand area
   int          res_ptr = 'h400;   // result area
   int          n_checked = 0;
   int          n_expected = 0;
   int          watchdog_ns = 0;
   logic        pending, pend_wr;  // bus request being answered
   logic [2:0]  delay;
   alu_op_t     ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                             ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
   logic [2:0]  f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};

   rv_core_tb_clk u_clk (.clk_o(clk), .reset_o(reset));

   rv_core DUT (
      .clk(clk), .reset(reset), .instruction_i(instruction_i), .pc_o(pc_o), .bus_o(bus_o),
      .bus_read_done_i(bus_read_done_i), .bus_write_done_i(bus_write_done_i),
      .bus_read_data_i(bus_read_data_i)
   );

   // galois lfsr, one step per bit
   function automatic word_t rand_bits(input int n);
      word_t r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r = {r[62:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction

   function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
   endfunction

   function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   // expected result straight from the isa rules
   function automatic word_t alu_ref(input alu_op_t op, input logic w, input word_t a,
                                     input word_t b);
      word_t       r;
      logic [5:0]  sh;
      logic [31:0] a32;
      sh  = w ? {1'b0, b[4:0]} : b[5:0];
      a32 = a[31:0];
      case (op)
         ALU_ADD:  r = a + b;
         ALU_SUB:  r = a - b;
         ALU_SLL:  r = a << sh;
         ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
         ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
         ALU_XOR:  r = a ^ b;
         ALU_SRL:  r = w ? word_t'(a32 >> sh) : (a >> sh);
         ALU_SRA:  r = w ? word_t'($signed(a32) >>> sh) : word_t'($signed(a) >>> sh);
         ALU_OR:   r = a | b;
         ALU_AND:  r = a & b;
         default:  r = b;
      endcase
      return w ? {{32{r[31]}}, r[31:0]} : r;
   endfunction

   function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t ext_ref(input logic [2:0] f3, input word_t raw);
      int    n;
      word_t m;
      n = 8 << f3[1:0];   // bits taken
      m = (f3[1:0] == 2'd3) ? '1 : ((64'd1 << n) - 1);
      if (!f3[2] && f3[1:0] != 2'd3 && raw[n-1]) return raw | ~m;   // sign extend
      return raw & m;
   endfunction

   // unwritten bytes follow a pattern over all address bits
   function automatic logic [7:0] read_byte(input addr_t a);
      if (dmem.exists(a)) return dmem[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {1'b0, a[38:32]} ^ 8'h5a;
   endfunction

   function automatic word_t read_word(input addr_t a);
      word_t r;
      r = '0;
      for (int k = 7; k >= 0; k--) r = {r[55:0], read_byte(a + addr_t'(k))};
      return r;
   endfunction

   function automatic void put_bytes(input addr_t a, input word_t d, input int n);
      for (int k = 0; k < n; k++) dmem[a + addr_t'(k)] = d[8*k +: 8];
   endfunction

   function automatic addr_t pc_now();
      return RAM_BASE + addr_t'(4 * imem.size());
   endfunction

   task automatic load_operand(input reg_idx_t rd, input word_t v);
      put_bytes(addr_t'(data_ptr), v, 8);
      imem.push_back(enc_i(12'(data_ptr), 5'd0, 3'd3, rd, OP_LOAD));   // ld
      data_ptr += 8;
   endtask

   // sd rs to the next result slot, expected only if reached
   task automatic store_result(input reg_idx_t rs, input word_t v, input logic reached);
      imem.push_back(enc_s(12'(res_ptr), rs, 5'd0, 3'd3));
      if (reached) begin
         exp_addr.push_back(addr_t'(res_ptr));
         exp_data.push_back(v);
         exp_type.push_back(3'd3);
      end
      res_ptr += 8;
   endtask

   task automatic arith(input int i, input logic w, input logic use_imm);
      word_t       a, b;
      logic [11:0] imm;
      logic        alt;
      logic        sh;
      alt = (i == 1 || i == 7);
      sh  = (f3s[i][1:0] == 2'b01);
      a   = rand_bits(64);
      load_operand(5'd1, a);
      if (use_imm) begin
         imm = sh ? (12'(rand_bits(w ? 5 : 6)) | (alt ? 12'h400 : 12'h000)) : 12'(rand_bits(12));
         b   = {{52{imm[11]}}, imm};   // shifts only use the low bits
         imem.push_back(enc_i(imm, 5'd1, f3s[i], 5'd3, w ? OP_IMM_W : OP_IMM));
      end else begin
         b = rand_bits(64);
         load_operand(5'd2, b);
         imem.push_back(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[i], 5'd3,
                              w ? OP_REG_W : OP_REG));
      end
      store_result(5'd3, alu_ref(ops[i], w, a, b), 1'b1);
   endtask

   task automatic build_program();
      word_t      a, b, v;
      addr_t      p;
      logic [7:0] off;
      logic [2:0] bf3 [6];
      bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      for (int i = 0; i < 10; i++) arith(i, 1'b0, 1'b0);
      for (int i = 0; i < 10; i++) if (i < 3 || i == 6 || i == 7) arith(i, 1'b1, 1'b0);
      for (int i = 0; i < 10; i++) if (i != 1) arith(i, 1'b0, 1'b1);
      for (int i = 0; i < 10; i++) if (i == 0 || i == 2 || i == 6 || i == 7) arith(i, 1'b1, 1'b1);
      for (int f = 0; f < 7; f++) begin   // every load width, odd offsets too
         p = addr_t'(data_ptr) + addr_t'(rand_bits(3));
         put_bytes(p, rand_bits(64), 8);
         imem.push_back(enc_i(12'(p), 5'd0, 3'(f), 5'd3, OP_LOAD));
         data_ptr += 16;
         store_result(5'd3, ext_ref(3'(f), read_word(p)), 1'b1);
      end
      imem.push_back(enc_i(12'h600, 5'd0, 3'd0, 5'd4, OP_IMM));   // x4 = store base
      for (int f = 0; f < 4; f++) begin
         v   = rand_bits(64);
         off = 8'(rand_bits(8));
         load_operand(5'd1, v);
         imem.push_back(enc_s({4'b0, off}, 5'd1, 5'd4, 3'(f)));
         exp_addr.push_back(addr_t'('h600) + addr_t'(off));
         exp_data.push_back(ext_ref(3'(f) | 3'b100, v));   // zero ext = width mask
         exp_type.push_back(3'(f));
      end
      for (int k = 0; k < 6; k++) begin
         a = rand_bits(64);
         b = rand_bits(1) ? a : rand_bits(64);
         load_operand(5'd1, a);
         load_operand(5'd2, b);
         imem.push_back(enc_i(12'(k + 1), 5'd0, 3'd0, 5'd5, OP_IMM));   // marker
         imem.push_back(enc_b(13'd8, 5'd2, 5'd1, bf3[k]));
         store_result(5'd5, word_t'(k + 1), !br_ref(bf3[k], a, b));   // skipped if taken
         imem.push_back(enc_i(12'h055, 5'd0, 3'd0, 5'd6, OP_IMM));
         store_result(5'd6, 64'h55, 1'b1);
      end
      p = pc_now();
      imem.push_back(enc_j(21'd8, 5'd7));   // jal over one store
      store_result(5'd0, '0, 1'b0);
      store_result(5'd7, word_t'(p + addr_t'(4)), 1'b1);
      p = pc_now();
      imem.push_back(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd8, OP_AUIPC));   // x8 = pc
      imem.push_back(enc_i(12'd13, 5'd8, 3'd0, 5'd7, OP_JALR));       // odd target, bit 0 dropped
      store_result(5'd0, '0, 1'b0);
      store_result(5'd7, word_t'(p + addr_t'(8)), 1'b1);
      imem.push_back(enc_j(21'd0, 5'd0));   // park in a self loop
   endtask

   task automatic check_data(input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: store data %h, expected %h", $time, got, exp);
         $display("Verification failed");
         $fatal(1, "store data mismatch");
      end
   endtask

   task automatic check_addr(input addr_t got, input addr_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: store address %h, expected %h", $time, got, exp);
         $display("Verification failed");
         $fatal(1, "store address mismatch");
      end
   endtask

   task automatic check_type(input ls_type_t got, input ls_type_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: store ls_type %0d, expected %0d", $time, got, exp);
         $display("Verification failed");
         $fatal(1, "store width mismatch");
      end
   endtask

   // instruction and data memory, both answer on the falling edge
   always @(negedge clk) begin
      addr_t off_pc;
      bus_read_done_i  = 1'b0;
      bus_write_done_i = 1'b0;
      if (reset && (bus_o.read_enable || bus_o.write_enable)) begin
         pending = 1'b1;
         pend_wr = bus_o.write_enable;
         delay   = 3'(rand_bits(3));   // 0 to 7 cycles
      end
      if (pending) begin
         if (delay == 3'd0) begin
            pending = 1'b0;
            if (pend_wr) begin
               put_bytes(bus_o.address, bus_o.write_data, 1 << bus_o.ls_type[1:0]);
               bus_write_done_i = 1'b1;
            end else begin
               bus_read_data_i = read_word(bus_o.address);
               bus_read_done_i = 1'b1;
            end
         end else begin
            delay = delay - 3'd1;
         end
      end
      off_pc = (pc_o - RAM_BASE) >> 2;
      instruction_i = (off_pc < addr_t'(imem.size())) ? imem[off_pc] : NOP_INSTR;
   end

   // compare every store against the expected sequence
   always @(negedge clk) begin
      if (reset && bus_o.write_enable) begin
         if (exp_addr.size() == 0) begin
            $display("store to %h at %0t ns that the program should not make", bus_o.address,
                     $time);
            $display("Verification failed");
            $fatal(1, "unexpected store");
         end else begin
            check_addr(bus_o.address, exp_addr.pop_front());
            check_data(bus_o.write_data, exp_data.pop_front());
            check_type(bus_o.ls_type, exp_type.pop_front());
            n_checked++;
         end
      end
   end

   initial begin
      wait (watchdog_ns > 0);
      #(watchdog_ns);
      $display("timeout: program did not finish within %0d ns", watchdog_ns);
      $display("Verification failed");
      $fatal(1, "watchdog");
   end

   initial begin
      instruction_i    = NOP_INSTR;
      bus_read_done_i  = 1'b0;
      bus_write_done_i = 1'b0;
      bus_read_data_i  = '0;
      pending          = 1'b0;
      pend_wr          = 1'b0;
      delay            = '0;
      build_program();
      n_expected  = exp_addr.size();
      watchdog_ns = imem.size() * 10 * 100;   // 10 cycles per instruction
      @(posedge reset);   // released on a falling edge, registers settled
      if (pc_o !== RAM_BASE || bus_o.read_enable !== 1'b0 || bus_o.write_enable !== 1'b0) begin
         $display("core not in its reset state: pc %h", pc_o);
         $display("Verification failed");
         $fatal(1, "reset state");
      end
      @(negedge clk);   // first ld executing, lsu still idle
      if (bus_o.read_enable !== 1'b0 || bus_o.write_enable !== 1'b0) begin
         $display("bus enable high at %0t ns before the first load issued", $time);
         $display("Verification failed");
         $fatal(1, "early enable");
      end
      @(negedge clk);   // request registered, read strobe out
      if (bus_o.read_enable !== 1'b1 || bus_o.write_enable !== 1'b0) begin
         $display("first load did not raise read enable one cycle after it executed");
         $display("Verification failed");
         $fatal(1, "first load");
      end
      wait (n_checked == n_expected);
      repeat (8) @(negedge clk);   // let a stray store show up
      if (n_checked == n_expected && exp_addr.size() == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- rv_core.f
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
rv_core_assert.sv
rv_core_tb_clk.sv
rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
   -f rv_core.f -o rv_core_sim &&
./obj_dir/rv_core_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
